// File: filelist.f
rtl/soc_bus_pkg.sv
rtl/pad_mux.sv
rtl/mmio_regs.sv
rtl/bus_decoder.sv
rtl/soc_bus_top.sv
verification/soc_bus_sva.sv
verification/tb_soc_bus.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_soc_bus \
  -f filelist.f --Mdir obj_dir -o tb_soc_bus \
  && ./obj_dir/tb_soc_bus \
  || { echo "simulation run did not succeed"; exit 1; }

// File: verification/tb_soc_bus.sv
`default_nettype none

module tb_soc_bus;
  import soc_bus_pkg::*;

  localparam int unsigned MEM_WORDS = 16384;
  localparam int unsigned RAM_AW = $clog2(MEM_WORDS);
  localparam int unsigned N_SRAM = 8;
  // about 55 accesses of two cycles each, with a wide margin
  localparam int unsigned TIMEOUT_CYCLES = 2000;
  localparam logic [31:0] UNMAPPED_ADDR = 32'h1000_0000;

  logic                clk_i = 1'b0;
  logic                rst_n_i;
  logic                xtal_in_i;
  logic                clk_pll_i;
  logic                clk_ext_sel_i;
  logic                trap_i;
  logic                mem_valid_i;
  logic [DATA_W-1:0]   mem_addr_i;
  logic [DATA_W-1:0]   mem_wdata_i;
  logic [STRB_W-1:0]   mem_wstrb_i;
  logic                mem_ready_o;
  logic [DATA_W-1:0]   mem_rdata_o;
  logic [STRB_W-1:0]   ram_wenb_o;
  logic [RAM_AW-1:0]   ram_addr_o;
  logic [DATA_W-1:0]   ram_wdata_o;
  logic [DATA_W-1:0]   ram_rdata_i = '0;
  logic [7:0]          hk_config_i;
  logic                hk_xtal_ena_i;
  logic                hk_reg_ena_i;
  logic                hk_pll_cp_ena_i;
  logic                hk_pll_vco_ena_i;
  logic                hk_pll_bias_ena_i;
  logic [3:0]          hk_pll_trim_i;
  logic [11:0]         hk_mfgr_id_i;
  logic [7:0]          hk_prod_id_i;
  logic [3:0]          hk_mask_rev_i;
  logic [GPIO_W-1:0]   gpio_in_i;
  logic [GPIO_W-1:0]   gpio_out_o;
  logic [GPIO_W-1:0]   gpio_outenb_o;
  logic [GPIO_W-1:0]   gpio_pullupb_o;
  logic [GPIO_W-1:0]   gpio_pulldownb_o;
  logic                irq_7_o;
  logic                irq_8_o;

  logic [DATA_W-1:0]   sram [MEM_WORDS];
  integer              seed = 32'hf407;
  int unsigned         cycle_cnt = 0;
  // sram strobes seen in the first cycle of the last access
  logic [STRB_W-1:0]   first_wenb;
  logic [RAM_AW-1:0]   first_ram_addr;

  soc_bus_top #(.MEM_WORDS(MEM_WORDS)) u_soc_bus_top (.*);

  always #4 clk_i = ~clk_i;

  // synchronous sram, one cycle read latency
  always @(posedge clk_i) begin
    for (int b = 0; b < STRB_W; b++) begin
      if (!ram_wenb_o[b]) begin
        sram[ram_addr_o][b*8 +: 8] <= ram_wdata_o[b*8 +: 8];
      end
    end
    ram_rdata_i <= sram[ram_addr_o];
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout: the bus stopped answering after %0d cycles", cycle_cnt);
      $display("Testbench failed");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("Testbench failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  function automatic logic [31:0] reg_addr(input mmio_reg_e off);
    return {MMIO_PAGE, off};
  endfunction

  // one request, held until ready, then one idle cycle
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata);
    int unsigned waited;
    waited = 0;
    mem_valid_i = 1'b1;
    mem_addr_i  = addr;
    mem_wdata_i = wdata;
    mem_wstrb_i = wstrb;
    #2;
    first_wenb     = ram_wenb_o;
    first_ram_addr = ram_addr_o;
    while (!mem_ready_o) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    rdata       = mem_rdata_o;
    mem_valid_i = 1'b0;
    mem_wstrb_i = '0;
    check_value("ready latency", 32'(waited), 32'd1);
    next_cycle();
  endtask

  task automatic sram_access(input logic [RAM_AW-1:0] widx, input logic [31:0] wdata,
                             input logic [3:0] wstrb, output logic [31:0] rdata);
    logic [3:0] exp_wenb;
    exp_wenb = ~wstrb;
    bus_access(32'({widx, 2'b00}), wdata, wstrb, rdata);
    check_value("ram_wenb_o", 32'(first_wenb), 32'(exp_wenb));
    check_value("ram_addr_o", 32'(first_ram_addr), 32'(widx));
  endtask

  task automatic reg_write(input mmio_reg_e off, input logic [31:0] wdata,
                           input logic [3:0] wstrb);
    logic [31:0] unused;
    bus_access(reg_addr(off), wdata, wstrb, unused);
  endtask

  task automatic reg_read(input mmio_reg_e off, output logic [31:0] rdata);
    bus_access(reg_addr(off), 32'h0, 4'h0, rdata);
  endtask

  initial begin
    logic [31:0]       rnd;
    logic [31:0]       rdata;
    logic [3:0]        strb;
    logic [RAM_AW-1:0] widx [N_SRAM];
    logic [31:0]       wexp [N_SRAM];
    logic [15:0]       exp_gpio;
    logic [15:0]       exp_oeb;
    logic [15:0]       exp_pu;
    logic [15:0]       exp_pd;

    rst_n_i     = 1'b0;
    xtal_in_i   = 1'b0;
    clk_pll_i   = 1'b0;
    trap_i      = 1'b0;
    mem_valid_i = 1'b0;
    mem_addr_i  = '0;
    mem_wdata_i = '0;
    mem_wstrb_i = '0;
    gpio_in_i   = '0;
    rnd = $random(seed);
    clk_ext_sel_i     = rnd[0];
    hk_xtal_ena_i     = rnd[1];
    hk_reg_ena_i      = rnd[2];
    hk_pll_cp_ena_i   = rnd[3];
    hk_pll_vco_ena_i  = rnd[4];
    hk_pll_bias_ena_i = rnd[5];
    hk_pll_trim_i     = rnd[11:8];
    hk_config_i       = rnd[23:16];
    hk_mask_rev_i     = rnd[31:28];
    rnd = $random(seed);
    hk_mfgr_id_i = rnd[11:0];
    hk_prod_id_i = rnd[23:16];

    // pads float and the bus is idle in reset
    repeat (2) @(posedge clk_i);
    #1;
    check_value("gpio_outenb_o", 32'(gpio_outenb_o), 32'h0000_ffff);
    check_value("ram_wenb_o", 32'(ram_wenb_o), 32'h0000_000f);
    check_value("mem_ready_o", 32'(mem_ready_o), 32'h0);
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    next_cycle();
    reg_read(GPIO_OEB, rdata);
    check_value("mem_rdata_o", rdata, 32'h0000_ffff);

    // sram, full word then a partial overwrite
    for (int i = 0; i < N_SRAM; i++) begin
      rnd = $random(seed);
      widx[i] = RAM_AW'(i * 1024 + rnd[9:0]);
      wexp[i] = $random(seed);
      sram_access(widx[i], wexp[i], 4'hf, rdata);
      rnd = $random(seed);
      strb = (rnd[3:0] == 4'h0) ? 4'h5 : rnd[3:0];
      rnd = $random(seed);
      sram_access(widx[i], rnd, strb, rdata);
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          wexp[i][b*8 +: 8] = rnd[b*8 +: 8];
        end
      end
    end
    for (int i = 0; i < N_SRAM; i++) begin
      sram_access(widx[i], 32'h0, 4'h0, rdata);
      check_value("mem_rdata_o", rdata, wexp[i]);
    end

    // gpio registers, one byte at a time
    exp_gpio = '0;
    exp_oeb  = 16'hffff;
    exp_pu   = '0;
    exp_pd   = '0;
    rnd = $random(seed);
    reg_write(GPIO_DATA, rnd, 4'b0001);
    exp_gpio[7:0] = rnd[7:0];
    rnd = $random(seed);
    reg_write(GPIO_DATA, rnd, 4'b0010);
    exp_gpio[15:8] = rnd[15:8];
    check_value("gpio_out_o", 32'(gpio_out_o), 32'(exp_gpio));
    rnd = $random(seed);
    reg_write(GPIO_OEB, rnd, 4'b0001);
    exp_oeb[7:0] = rnd[7:0];
    check_value("gpio_outenb_o", 32'(gpio_outenb_o), 32'(exp_oeb));
    rnd = $random(seed);
    reg_write(GPIO_PU, rnd, 4'b0010);
    exp_pu[15:8] = rnd[15:8];
    check_value("gpio_pullupb_o", 32'(gpio_pullupb_o), 32'(exp_pu));
    rnd = $random(seed);
    reg_write(GPIO_PD, rnd, 4'b0001);
    exp_pd[7:0] = rnd[7:0];
    check_value("gpio_pulldownb_o", 32'(gpio_pulldownb_o), 32'(exp_pd));
    reg_read(GPIO_PU, rdata);
    check_value("mem_rdata_o", rdata, 32'(exp_pu));
    reg_read(GPIO_PD, rdata);
    check_value("mem_rdata_o", rdata, 32'(exp_pd));
    rnd = $random(seed);
    gpio_in_i = rnd[15:0];
    reg_read(GPIO_DATA, rdata);
    check_value("mem_rdata_o", rdata, {exp_gpio, gpio_in_i});

    // housekeeping status, read only
    reg_read(HK_CONFIG, rdata);
    check_value("mem_rdata_o", rdata, 32'(hk_config_i));
    reg_read(HK_ENA, rdata);
    check_value("mem_rdata_o", rdata, 32'({hk_xtal_ena_i, hk_reg_ena_i}));
    reg_read(HK_PLL, rdata);
    check_value("mem_rdata_o", rdata, 32'({hk_pll_trim_i, hk_pll_cp_ena_i,
                                           hk_pll_vco_ena_i, hk_pll_bias_ena_i}));
    reg_read(HK_PROD, rdata);
    check_value("mem_rdata_o", rdata, 32'(hk_prod_id_i));
    reg_read(HK_MASK, rdata);
    check_value("mem_rdata_o", rdata, 32'(hk_mask_rev_i));
    reg_read(HK_CLKSEL, rdata);
    check_value("mem_rdata_o", rdata, 32'(clk_ext_sel_i));
    reg_write(HK_MFGR, 32'hffff_ffff, 4'hf);
    reg_read(HK_MFGR, rdata);
    check_value("mem_rdata_o", rdata, 32'(hk_mfgr_id_i));
    reg_write(HK_CONFIG, 32'hffff_ffff, 4'hf);
    reg_read(HK_CONFIG, rdata);
    check_value("mem_rdata_o", rdata, 32'(hk_config_i));

    // unmapped space and holes in the register page read zero
    // low bits point at a written sram word
    bus_access(UNMAPPED_ADDR | 32'({widx[0], 2'b00}), 32'hdead_beef, 4'hf, rdata);
    check_value("ram_wenb_o", 32'(first_wenb), 32'h0000_000f);
    bus_access(UNMAPPED_ADDR | 32'({widx[0], 2'b00}), 32'h0, 4'h0, rdata);
    check_value("mem_rdata_o", rdata, 32'h0);
    bus_access({MMIO_PAGE, 8'h10}, 32'h0, 4'h0, rdata);
    check_value("mem_rdata_o", rdata, 32'h0);

    // crystal on pad 6, trap on pad 13
    reg_write(XTAL_DEST, 32'(ROUTE_2), 4'h1);
    reg_write(TRAP_DEST, 32'(ROUTE_3), 4'h1);
    for (int k = 0; k < 2; k++) begin
      xtal_in_i = (k == 0);
      trap_i    = (k != 0);
      next_cycle();
      check_value("gpio_out_o[6]", 32'(gpio_out_o[6]), 32'(xtal_in_i));
      check_value("gpio_out_o[13]", 32'(gpio_out_o[13]), 32'(trap_i));
    end
    check_value("gpio_outenb_o[7:5]", 32'(gpio_outenb_o[7:5]), 32'h0);
    check_value("gpio_pullupb_o[7:5]", 32'(gpio_pullupb_o[7:5]), 32'h7);
    check_value("gpio_pulldownb_o[7:5]", 32'(gpio_pulldownb_o[7:5]), 32'h7);
    check_value("gpio_outenb_o[13:11]", 32'(gpio_outenb_o[13:11]), 32'h0);
    reg_write(XTAL_DEST, 32'(ROUTE_OFF), 4'h1);
    reg_write(TRAP_DEST, 32'(ROUTE_OFF), 4'h1);
    check_value("gpio_out_o", 32'(gpio_out_o), 32'(exp_gpio));
    check_value("gpio_outenb_o", 32'(gpio_outenb_o), 32'(exp_oeb));
    check_value("gpio_pullupb_o", 32'(gpio_pullupb_o), 32'(exp_pu));
    check_value("gpio_pulldownb_o", 32'(gpio_pulldownb_o), 32'(exp_pd));

    // irq 7 from pad 1, irq 8 from pad 5
    reg_write(IRQ7_SRC, 32'(ROUTE_2), 4'h1);
    reg_write(IRQ8_SRC, 32'(ROUTE_3), 4'h1);
    for (int k = 0; k < 2; k++) begin
      gpio_in_i = (k == 0) ? 16'h0002 : 16'h0020;
      next_cycle();
      check_value("irq_7_o", 32'(irq_7_o), 32'(gpio_in_i[1]));
      check_value("irq_8_o", 32'(irq_8_o), 32'(gpio_in_i[5]));
    end
    reg_write(IRQ7_SRC, 32'(ROUTE_OFF), 4'h1);
    reg_write(IRQ8_SRC, 32'(ROUTE_OFF), 4'h1);
    gpio_in_i = 16'hffff;
    next_cycle();
    check_value("irq_7_o", 32'(irq_7_o), 32'h0);
    check_value("irq_8_o", 32'(irq_8_o), 32'h0);

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/soc_bus_sva.sv
`default_nettype none

module soc_bus_sva (
  input wire                            clk_i,
  input wire                            rst_n_i,
  input wire                            mem_valid_i,
  input wire                            mem_ready_i,
  input wire [soc_bus_pkg::STRB_W-1:0]  ram_wenb_i
);

  // first cycle of a request as seen by the decoder
  logic new_req;

  assign new_req = mem_valid_i && !mem_ready_i;

  // ready is a single-cycle pulse
  ready_single_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    mem_ready_i |=> !mem_ready_i
  ) else $error("mem_ready high for two cycles in a row");

  ready_after_request: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    new_req |=> mem_ready_i
  ) else $error("mem_ready missing one cycle after a new request");

  // byte enables only in the first cycle of an access
  wenb_in_first_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (ram_wenb_i != '1) |-> new_req
  ) else $error("ram_wenb active outside the first cycle of a request");

endmodule

bind bus_decoder soc_bus_sva u_soc_bus_sva (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .mem_valid_i(mem_valid_i),
  .mem_ready_i(mem_ready_o),
  .ram_wenb_i (ram_wenb_o)
);

`default_nettype wire

// File: rtl/soc_bus_top.sv
`default_nettype none

module soc_bus_top #(
  parameter int unsigned MEM_WORDS = 16384
) (
  input  wire                                 clk_i,
  input  wire                                 rst_n_i,
  input  wire                                 xtal_in_i,
  input  wire                                 clk_pll_i,
  input  wire                                 clk_ext_sel_i,
  input  wire                                 trap_i,
  // native memory bus
  input  wire                                 mem_valid_i,
  input  wire  [soc_bus_pkg::DATA_W-1:0]      mem_addr_i,
  input  wire  [soc_bus_pkg::DATA_W-1:0]      mem_wdata_i,
  input  wire  [soc_bus_pkg::STRB_W-1:0]      mem_wstrb_i,
  output logic                                mem_ready_o,
  output logic [soc_bus_pkg::DATA_W-1:0]      mem_rdata_o,
  // sram macro
  output logic [soc_bus_pkg::STRB_W-1:0]      ram_wenb_o,
  output logic [$clog2(MEM_WORDS)-1:0]        ram_addr_o,
  output logic [soc_bus_pkg::DATA_W-1:0]      ram_wdata_o,
  input  wire  [soc_bus_pkg::DATA_W-1:0]      ram_rdata_i,
  // housekeeping status
  input  wire  [7:0]                          hk_config_i,
  input  wire                                 hk_xtal_ena_i,
  input  wire                                 hk_reg_ena_i,
  input  wire                                 hk_pll_cp_ena_i,
  input  wire                                 hk_pll_vco_ena_i,
  input  wire                                 hk_pll_bias_ena_i,
  input  wire  [3:0]                          hk_pll_trim_i,
  input  wire  [11:0]                         hk_mfgr_id_i,
  input  wire  [7:0]                          hk_prod_id_i,
  input  wire  [3:0]                          hk_mask_rev_i,
  // pads
  input  wire  [soc_bus_pkg::GPIO_W-1:0]      gpio_in_i,
  output logic [soc_bus_pkg::GPIO_W-1:0]      gpio_out_o,
  output logic [soc_bus_pkg::GPIO_W-1:0]      gpio_outenb_o,
  output logic [soc_bus_pkg::GPIO_W-1:0]      gpio_pullupb_o,
  output logic [soc_bus_pkg::GPIO_W-1:0]      gpio_pulldownb_o,
  output logic                                irq_7_o,
  output logic                                irq_8_o
);
  import soc_bus_pkg::*;

  // register page request
  logic              mmio_req;
  mmio_reg_e         mmio_offset;
  logic [DATA_W-1:0] mmio_wdata;
  logic [STRB_W-1:0] mmio_wstrb;
  logic [DATA_W-1:0] mmio_rdata;

  // register values towards the pads
  logic [GPIO_W-1:0] gpio;
  logic [GPIO_W-1:0] gpio_oeb;
  logic [GPIO_W-1:0] gpio_pu;
  logic [GPIO_W-1:0] gpio_pd;
  route_e            xtal_dest;
  route_e            pll_dest;
  route_e            trap_dest;
  route_e            irq7_src;
  route_e            irq8_src;

  bus_decoder #(
    .MEM_WORDS(MEM_WORDS)
  ) u_bus_decoder (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .mem_valid_i  (mem_valid_i),
    .mem_addr_i   (mem_addr_i),
    .mem_wdata_i  (mem_wdata_i),
    .mem_wstrb_i  (mem_wstrb_i),
    .mem_ready_o  (mem_ready_o),
    .mem_rdata_o  (mem_rdata_o),
    .ram_wenb_o   (ram_wenb_o),
    .ram_addr_o   (ram_addr_o),
    .ram_wdata_o  (ram_wdata_o),
    .ram_rdata_i  (ram_rdata_i),
    .mmio_req_o   (mmio_req),
    .mmio_offset_o(mmio_offset),
    .mmio_wdata_o (mmio_wdata),
    .mmio_wstrb_o (mmio_wstrb),
    .mmio_rdata_i (mmio_rdata)
  );

  mmio_regs u_mmio_regs (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .mmio_req_i       (mmio_req),
    .mmio_offset_i    (mmio_offset),
    .mmio_wdata_i     (mmio_wdata),
    .mmio_wstrb_i     (mmio_wstrb),
    .mmio_rdata_o     (mmio_rdata),
    .gpio_in_i        (gpio_in_i),
    .gpio_pads_i      (gpio_out_o),
    .clk_ext_sel_i    (clk_ext_sel_i),
    .hk_config_i      (hk_config_i),
    .hk_xtal_ena_i    (hk_xtal_ena_i),
    .hk_reg_ena_i     (hk_reg_ena_i),
    .hk_pll_cp_ena_i  (hk_pll_cp_ena_i),
    .hk_pll_vco_ena_i (hk_pll_vco_ena_i),
    .hk_pll_bias_ena_i(hk_pll_bias_ena_i),
    .hk_pll_trim_i    (hk_pll_trim_i),
    .hk_mfgr_id_i     (hk_mfgr_id_i),
    .hk_prod_id_i     (hk_prod_id_i),
    .hk_mask_rev_i    (hk_mask_rev_i),
    .gpio_o           (gpio),
    .gpio_oeb_o       (gpio_oeb),
    .gpio_pu_o        (gpio_pu),
    .gpio_pd_o        (gpio_pd),
    .xtal_dest_o      (xtal_dest),
    .pll_dest_o       (pll_dest),
    .trap_dest_o      (trap_dest),
    .irq7_src_o       (irq7_src),
    .irq8_src_o       (irq8_src)
  );

  pad_mux u_pad_mux (
    .rst_n_i         (rst_n_i),
    .xtal_in_i       (xtal_in_i),
    .clk_pll_i       (clk_pll_i),
    .clk_i           (clk_i),
    .trap_i          (trap_i),
    .gpio_in_i       (gpio_in_i),
    .gpio_i          (gpio),
    .gpio_oeb_i      (gpio_oeb),
    .gpio_pu_i       (gpio_pu),
    .gpio_pd_i       (gpio_pd),
    .xtal_dest_i     (xtal_dest),
    .pll_dest_i      (pll_dest),
    .trap_dest_i     (trap_dest),
    .irq7_src_i      (irq7_src),
    .irq8_src_i      (irq8_src),
    .gpio_out_o      (gpio_out_o),
    .gpio_outenb_o   (gpio_outenb_o),
    .gpio_pullupb_o  (gpio_pullupb_o),
    .gpio_pulldownb_o(gpio_pulldownb_o),
    .irq_7_o         (irq_7_o),
    .irq_8_o         (irq_8_o)
  );

endmodule

`default_nettype wire

// File: rtl/bus_decoder.sv
`default_nettype none

module bus_decoder #(
  parameter int unsigned MEM_WORDS = 16384
) (
  input  wire                            clk_i,
  input  wire                            rst_n_i,
  // requester side
  input  wire                            mem_valid_i,
  input  wire  [soc_bus_pkg::DATA_W-1:0] mem_addr_i,
  input  wire  [soc_bus_pkg::DATA_W-1:0] mem_wdata_i,
  input  wire  [soc_bus_pkg::STRB_W-1:0] mem_wstrb_i,
  output logic                           mem_ready_o,
  output logic [soc_bus_pkg::DATA_W-1:0] mem_rdata_o,
  // sram side
  output logic [soc_bus_pkg::STRB_W-1:0] ram_wenb_o,
  output logic [$clog2(MEM_WORDS)-1:0]   ram_addr_o,
  output logic [soc_bus_pkg::DATA_W-1:0] ram_wdata_o,
  input  wire  [soc_bus_pkg::DATA_W-1:0] ram_rdata_i,
  // register page side
  output logic                           mmio_req_o,
  output soc_bus_pkg::mmio_reg_e         mmio_offset_o,
  output logic [soc_bus_pkg::DATA_W-1:0] mmio_wdata_o,
  output logic [soc_bus_pkg::STRB_W-1:0] mmio_wstrb_o,
  input  wire  [soc_bus_pkg::DATA_W-1:0] mmio_rdata_i
);
  import soc_bus_pkg::*;

  localparam int unsigned RAM_AW = $clog2(MEM_WORDS);

  typedef enum logic [1:0] {
    TGT_NONE,
    TGT_SRAM,
    TGT_MMIO
  } target_e;

  logic    start;
  logic    sram_hit;
  logic    mmio_hit;
  target_e req_tgt;
  target_e tgt_q;
  logic    ready_q;

  // first cycle of a request, never the ready cycle itself
  assign start    = mem_valid_i && !ready_q;
  // byte address below 4*MEM_WORDS
  assign sram_hit = mem_addr_i[DATA_W-1:RAM_AW+2] == '0;
  assign mmio_hit = mem_addr_i[DATA_W-1:8] == MMIO_PAGE;

  always_comb begin
    if (sram_hit) begin
      req_tgt = TGT_SRAM;
    end else if (mmio_hit) begin
      req_tgt = TGT_MMIO;
    end else begin
      req_tgt = TGT_NONE;
    end
  end

  // sram strobes only during the first cycle
  assign ram_wenb_o  = (start && sram_hit) ? ~mem_wstrb_i : '1;
  assign ram_addr_o  = mem_addr_i[RAM_AW+1:2];
  assign ram_wdata_o = mem_wdata_i;

  assign mmio_req_o    = start && (req_tgt == TGT_MMIO);
  assign mmio_offset_o = mmio_reg_e'(mem_addr_i[7:0]);
  assign mmio_wdata_o  = mem_wdata_i;
  assign mmio_wstrb_o  = mem_wstrb_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
      tgt_q   <= TGT_NONE;
    end else begin
      ready_q <= start;
      if (start) begin
        tgt_q <= req_tgt;
      end
    end
  end

  assign mem_ready_o = ready_q;

  // unmapped addresses answer with zero
  always_comb begin
    mem_rdata_o = '0;
    if (ready_q) begin
      case (tgt_q)
        TGT_SRAM: mem_rdata_o = ram_rdata_i;
        TGT_MMIO: mem_rdata_o = mmio_rdata_i;
        default:  mem_rdata_o = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/mmio_regs.sv
`default_nettype none

module mmio_regs (
  input  wire                            clk_i,
  input  wire                            rst_n_i,
  // request strobe from the decoder
  input  wire                            mmio_req_i,
  input  wire  soc_bus_pkg::mmio_reg_e   mmio_offset_i,
  input  wire  [soc_bus_pkg::DATA_W-1:0] mmio_wdata_i,
  input  wire  [soc_bus_pkg::STRB_W-1:0] mmio_wstrb_i,
  output logic [soc_bus_pkg::DATA_W-1:0] mmio_rdata_o,
  // pad state for readback
  input  wire  [soc_bus_pkg::GPIO_W-1:0] gpio_in_i,
  input  wire  [soc_bus_pkg::GPIO_W-1:0] gpio_pads_i,
  // housekeeping status
  input  wire                            clk_ext_sel_i,
  input  wire  [7:0]                     hk_config_i,
  input  wire                            hk_xtal_ena_i,
  input  wire                            hk_reg_ena_i,
  input  wire                            hk_pll_cp_ena_i,
  input  wire                            hk_pll_vco_ena_i,
  input  wire                            hk_pll_bias_ena_i,
  input  wire  [3:0]                     hk_pll_trim_i,
  input  wire  [11:0]                    hk_mfgr_id_i,
  input  wire  [7:0]                     hk_prod_id_i,
  input  wire  [3:0]                     hk_mask_rev_i,
  // register values
  output logic [soc_bus_pkg::GPIO_W-1:0] gpio_o,
  output logic [soc_bus_pkg::GPIO_W-1:0] gpio_oeb_o,
  output logic [soc_bus_pkg::GPIO_W-1:0] gpio_pu_o,
  output logic [soc_bus_pkg::GPIO_W-1:0] gpio_pd_o,
  output soc_bus_pkg::route_e            xtal_dest_o,
  output soc_bus_pkg::route_e            pll_dest_o,
  output soc_bus_pkg::route_e            trap_dest_o,
  output soc_bus_pkg::route_e            irq7_src_o,
  output soc_bus_pkg::route_e            irq8_src_o
);
  import soc_bus_pkg::*;

  logic   sel_we;
  route_e sel_wdata;

  // byte-wise update of a gpio register
  function automatic logic [GPIO_W-1:0] merge_bytes(
    input logic [GPIO_W-1:0] cur,
    input logic [DATA_W-1:0] wdata,
    input logic [STRB_W-1:0] wstrb
  );
    logic [GPIO_W-1:0] res;
    res = cur;
    for (int b = 0; b < GPIO_W / 8; b++) begin
      if (wstrb[b]) begin
        res[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // selectors only take byte 0
  assign sel_we    = mmio_req_i && mmio_wstrb_i[0];
  assign sel_wdata = route_e'(mmio_wdata_i[1:0]);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_o      <= '0;
      gpio_oeb_o  <= GPIO_OEB_RESET;
      gpio_pu_o   <= '0;
      gpio_pd_o   <= '0;
      xtal_dest_o <= ROUTE_OFF;
      pll_dest_o  <= ROUTE_OFF;
      trap_dest_o <= ROUTE_OFF;
      irq7_src_o  <= ROUTE_OFF;
      irq8_src_o  <= ROUTE_OFF;
    end else if (mmio_req_i) begin
      case (mmio_offset_i)
        GPIO_DATA: gpio_o     <= merge_bytes(gpio_o, mmio_wdata_i, mmio_wstrb_i);
        GPIO_OEB:  gpio_oeb_o <= merge_bytes(gpio_oeb_o, mmio_wdata_i, mmio_wstrb_i);
        GPIO_PU:   gpio_pu_o  <= merge_bytes(gpio_pu_o, mmio_wdata_i, mmio_wstrb_i);
        GPIO_PD:   gpio_pd_o  <= merge_bytes(gpio_pd_o, mmio_wdata_i, mmio_wstrb_i);
        XTAL_DEST: begin
          if (sel_we) begin
            xtal_dest_o <= sel_wdata;
          end
        end
        PLL_DEST: begin
          if (sel_we) begin
            pll_dest_o <= sel_wdata;
          end
        end
        TRAP_DEST: begin
          if (sel_we) begin
            trap_dest_o <= sel_wdata;
          end
        end
        IRQ7_SRC: begin
          if (sel_we) begin
            irq7_src_o <= sel_wdata;
          end
        end
        IRQ8_SRC: begin
          if (sel_we) begin
            irq8_src_o <= sel_wdata;
          end
        end
        // housekeeping words and holes ignore writes
        default: begin
        end
      endcase
    end
  end

  // readback captured on the request edge, before the write lands
  always_ff @(posedge clk_i) begin
    if (mmio_req_i) begin
      case (mmio_offset_i)
        GPIO_DATA: mmio_rdata_o <= DATA_W'({gpio_pads_i, gpio_in_i});
        GPIO_OEB:  mmio_rdata_o <= DATA_W'(gpio_oeb_o);
        GPIO_PU:   mmio_rdata_o <= DATA_W'(gpio_pu_o);
        GPIO_PD:   mmio_rdata_o <= DATA_W'(gpio_pd_o);
        HK_CONFIG: mmio_rdata_o <= DATA_W'(hk_config_i);
        HK_ENA:    mmio_rdata_o <= DATA_W'({hk_xtal_ena_i, hk_reg_ena_i});
        HK_PLL: begin
          mmio_rdata_o <= DATA_W'({hk_pll_trim_i, hk_pll_cp_ena_i,
                                   hk_pll_vco_ena_i, hk_pll_bias_ena_i});
        end
        HK_MFGR:   mmio_rdata_o <= DATA_W'(hk_mfgr_id_i);
        HK_PROD:   mmio_rdata_o <= DATA_W'(hk_prod_id_i);
        HK_MASK:   mmio_rdata_o <= DATA_W'(hk_mask_rev_i);
        HK_CLKSEL: mmio_rdata_o <= DATA_W'(clk_ext_sel_i);
        XTAL_DEST: mmio_rdata_o <= DATA_W'(xtal_dest_o);
        PLL_DEST:  mmio_rdata_o <= DATA_W'(pll_dest_o);
        TRAP_DEST: mmio_rdata_o <= DATA_W'(trap_dest_o);
        IRQ7_SRC:  mmio_rdata_o <= DATA_W'(irq7_src_o);
        IRQ8_SRC:  mmio_rdata_o <= DATA_W'(irq8_src_o);
        default:   mmio_rdata_o <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/pad_mux.sv
`default_nettype none

module pad_mux (
  input  wire                            rst_n_i,
  input  wire                            xtal_in_i,
  input  wire                            clk_pll_i,
  input  wire                            clk_i,
  input  wire                            trap_i,
  input  wire  [soc_bus_pkg::GPIO_W-1:0] gpio_in_i,
  // register values
  input  wire  [soc_bus_pkg::GPIO_W-1:0] gpio_i,
  input  wire  [soc_bus_pkg::GPIO_W-1:0] gpio_oeb_i,
  input  wire  [soc_bus_pkg::GPIO_W-1:0] gpio_pu_i,
  input  wire  [soc_bus_pkg::GPIO_W-1:0] gpio_pd_i,
  input  wire  soc_bus_pkg::route_e      xtal_dest_i,
  input  wire  soc_bus_pkg::route_e      pll_dest_i,
  input  wire  soc_bus_pkg::route_e      trap_dest_i,
  input  wire  soc_bus_pkg::route_e      irq7_src_i,
  input  wire  soc_bus_pkg::route_e      irq8_src_i,
  // pads and interrupts
  output logic [soc_bus_pkg::GPIO_W-1:0] gpio_out_o,
  output logic [soc_bus_pkg::GPIO_W-1:0] gpio_outenb_o,
  output logic [soc_bus_pkg::GPIO_W-1:0] gpio_pullupb_o,
  output logic [soc_bus_pkg::GPIO_W-1:0] gpio_pulldownb_o,
  output logic                           irq_7_o,
  output logic                           irq_8_o
);
  import soc_bus_pkg::*;

  // pads owned by an active route
  logic [GPIO_W-1:0] route_mask;

  function automatic logic pick_src(input route_e sel, input logic [2:0] src);
    case (sel)
      ROUTE_1: return src[0];
      ROUTE_2: return src[1];
      ROUTE_3: return src[2];
      default: return 1'b0;
    endcase
  endfunction

  assign route_mask[4:0]        = '0;
  assign route_mask[7:5]        = {3{xtal_dest_i != ROUTE_OFF}};
  assign route_mask[10:8]       = {3{pll_dest_i != ROUTE_OFF}};
  assign route_mask[13:11]      = {3{trap_dest_i != ROUTE_OFF}};
  assign route_mask[GPIO_W-1:14] = '0;

  always_comb begin
    gpio_out_o = gpio_i;
    case (xtal_dest_i)
      ROUTE_1: gpio_out_o[5] = xtal_in_i;
      ROUTE_2: gpio_out_o[6] = xtal_in_i;
      ROUTE_3: gpio_out_o[7] = xtal_in_i;
      default: gpio_out_o[7:5] = gpio_i[7:5];
    endcase
    // value 3 keeps pad 10 on the register
    case (pll_dest_i)
      ROUTE_1: gpio_out_o[8] = clk_pll_i;
      ROUTE_2: gpio_out_o[9] = clk_i;
      default: gpio_out_o[10:8] = gpio_i[10:8];
    endcase
    case (trap_dest_i)
      ROUTE_1: gpio_out_o[11] = trap_i;
      ROUTE_2: gpio_out_o[12] = trap_i;
      ROUTE_3: gpio_out_o[13] = trap_i;
      default: gpio_out_o[13:11] = gpio_i[13:11];
    endcase
  end

  // routed pads drive with both pulls off, all pads float in reset
  assign gpio_outenb_o    = (gpio_oeb_i & ~route_mask) | {GPIO_W{~rst_n_i}};
  assign gpio_pullupb_o   = gpio_pu_i | route_mask;
  assign gpio_pulldownb_o = gpio_pd_i | route_mask;

  assign irq_7_o = pick_src(irq7_src_i, gpio_in_i[2:0]);
  assign irq_8_o = pick_src(irq8_src_i, gpio_in_i[5:3]);

endmodule

`default_nettype wire

// File: rtl/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

  // bus geometry
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;
  localparam int unsigned GPIO_W = 16;

  // upper address bits of the on-chip register page
  localparam logic [23:0] MMIO_PAGE = 24'h0300_00;

  // register offsets inside the page
  typedef enum logic [7:0] {
    GPIO_DATA = 8'h00,
    GPIO_OEB  = 8'h04,
    GPIO_PU   = 8'h08,
    GPIO_PD   = 8'h0C,
    // housekeeping status, read only
    HK_CONFIG = 8'h18,
    HK_ENA    = 8'h1C,
    HK_PLL    = 8'h20,
    HK_MFGR   = 8'h24,
    HK_PROD   = 8'h28,
    HK_MASK   = 8'h2C,
    HK_CLKSEL = 8'h30,
    // pad routing and irq sources
    XTAL_DEST = 8'h34,
    PLL_DEST  = 8'h38,
    TRAP_DEST = 8'h3C,
    IRQ7_SRC  = 8'h40,
    IRQ8_SRC  = 8'h44
  } mmio_reg_e;

  // shared by the pad routing and the irq source selectors
  typedef enum logic [1:0] {
    ROUTE_OFF = 2'd0,
    ROUTE_1   = 2'd1,
    ROUTE_2   = 2'd2,
    ROUTE_3   = 2'd3
  } route_e;

  // pads come up as inputs
  localparam logic [GPIO_W-1:0] GPIO_OEB_RESET = '1;

endpackage

`default_nettype wire
